/* Bender.yml */
package:
  name: gb_cpu

sources:
  - cpu_pkg.sv
  - reg_wr_if.sv
  - alu8.sv
  - reg_file.sv
  - cpu_sequencer.sv
  - gb_cpu.sv
  - target: test
    files:
      - gb_cpu_chk.sv
      - tb_gb_cpu.sv

/* alu8.sv */
module alu8 (
	input cpu_pkg::alu_op_t op,
	input logic [cpu_pkg::data_w-1:0] acc, // Also the INC/DEC operand
	input logic [cpu_pkg::data_w-1:0] arg,
	input logic carry_in,
	output logic [cpu_pkg::data_w-1:0] result,
	output logic [cpu_pkg::flag_z:cpu_pkg::flag_c] flags
);

	logic [cpu_pkg::data_w:0] wide; // Carry or borrow out of bit 7 on top
	logic [4:0] nib; // Carry or borrow out of bit 3 on top
	logic cin; // Carry only for ADC and SBC
	logic sub; // N flag
	logic incdec;

	assign cin = (op == cpu_pkg::alu_adc || op == cpu_pkg::alu_sbc) && carry_in;
	assign incdec = op == cpu_pkg::alu_inc || op == cpu_pkg::alu_dec;

	always_comb
	begin
		wide = '0;
		nib = '0;
		sub = 1'b0;
		case (op)
			cpu_pkg::alu_add, cpu_pkg::alu_adc:
			begin
				wide = {1'b0, acc} + {1'b0, arg} + cin;
				nib = {1'b0, acc[3:0]} + {1'b0, arg[3:0]} + cin;
			end
			cpu_pkg::alu_sub, cpu_pkg::alu_sbc, cpu_pkg::alu_cp:
			begin
				wide = {1'b0, acc} - {1'b0, arg} - cin; // Top bit is borrow
				nib = {1'b0, acc[3:0]} - {1'b0, arg[3:0]} - cin;
				sub = 1'b1;
			end
			cpu_pkg::alu_and:
			begin
				wide = {1'b0, acc & arg};
				nib = 5'h10; // H forced high
			end
			cpu_pkg::alu_xor:
				wide = {1'b0, acc ^ arg};
			cpu_pkg::alu_or:
				wide = {1'b0, acc | arg};
			cpu_pkg::alu_inc:
			begin
				wide = {1'b0, acc} + 9'd1;
				nib = {1'b0, acc[3:0]} + 5'd1;
			end
			cpu_pkg::alu_dec:
			begin
				wide = {1'b0, acc} - 9'd1;
				nib = {1'b0, acc[3:0]} - 5'd1;
				sub = 1'b1;
			end
			default:
				wide = {1'b0, acc}; // Unused codes pass A
		endcase
	end

	assign result = wide[cpu_pkg::data_w-1:0];

	// Flag nibble
	always_comb
	begin
		flags[cpu_pkg::flag_z] = result == '0;
		flags[cpu_pkg::flag_n] = sub;
		flags[cpu_pkg::flag_h] = nib[4];
		flags[cpu_pkg::flag_c] = incdec ? carry_in : wide[cpu_pkg::data_w]; // INC/DEC keep C
	end

endmodule

/* cpu_pkg.sv */
package cpu_pkg;

	// Bus and datapath widths
	localparam int data_w = 8; // Data byte
	localparam int addr_w = 16; // Memory address

	// Machine states, one per 4-clock machine cycle
	typedef enum logic [2:0]
	{
		st_ifetch = 3'd0, // Opcode fetch, execution of 1-cycle ops
		st_imml_fetch = 3'd1, // Immediate low byte, or the only immediate
		st_immh_fetch = 3'd2, // Immediate high byte of JP
		st_jump = 3'd3, // Idle cycle, pc loaded at its end
		st_store = 3'd4 // High-page write of A
	} state_t;

	// ALU operations, the first eight match opcode bits 5..3
	typedef enum logic [3:0]
	{
		alu_add = 4'd0,
		alu_adc = 4'd1, // Adds incoming C
		alu_sub = 4'd2,
		alu_sbc = 4'd3, // Subtracts incoming C
		alu_and = 4'd4,
		alu_xor = 4'd5,
		alu_or = 4'd6,
		alu_cp = 4'd7, // Subtract for flags only
		alu_inc = 4'd8, // Destination register plus one
		alu_dec = 4'd9 // Destination register minus one
	} alu_op_t;

	// Register index as encoded in the opcode fields
	// B=0 C=1 D=2 E=3 H=4 L=5, slot 6 is the (HL) operand, A=7
	typedef logic [2:0] reg_idx_t;

	localparam reg_idx_t reg_none = 3'd6; // (HL) slot, no register behind it
	localparam reg_idx_t reg_a = 3'd7; // Accumulator

	// Flag bit positions within F, the low nibble of F is always zero
	localparam int flag_z = 7; // Zero
	localparam int flag_n = 6; // Subtraction
	localparam int flag_h = 5; // Half carry
	localparam int flag_c = 4; // Carry

	// Upper address byte of LD (a8),A
	localparam logic [data_w-1:0] high_page = 8'hff;

endpackage

/* cpu_sequencer.sv */
module cpu_sequencer #(
	parameter logic [cpu_pkg::addr_w-1:0] RESET_PC = '0
) (
	input logic clk,
	input logic reset,
	output logic [cpu_pkg::addr_w-1:0] adr,
	output logic [cpu_pkg::data_w-1:0] dout,
	input logic [cpu_pkg::data_w-1:0] din,
	output logic read,
	output logic write,
	output logic [cpu_pkg::addr_w-1:0] pc,
	reg_wr_if.seq wr,
	output cpu_pkg::reg_idx_t src_idx,
	input logic [cpu_pkg::data_w-1:0] src_data,
	input logic [cpu_pkg::data_w-1:0] acc,
	output cpu_pkg::alu_op_t alu_op,
	output logic [cpu_pkg::data_w-1:0] alu_arg,
	input logic [cpu_pkg::data_w-1:0] alu_result,
	input logic [cpu_pkg::flag_z:cpu_pkg::flag_c] alu_flags
);

	localparam logic [cpu_pkg::data_w-1:0] op_jp = 8'hc3; // JP a16
	localparam logic [cpu_pkg::data_w-1:0] op_st_a8 = 8'he0; // LD (a8),A

	logic [1:0] cycle; // Clock within the machine cycle
	cpu_pkg::state_t state;
	cpu_pkg::state_t state_next; // Taken at the end of clock 3
	logic [cpu_pkg::data_w-1:0] op;
	logic [cpu_pkg::data_w-1:0] imml;
	logic [cpu_pkg::data_w-1:0] immh;
	logic fetching; // Machine cycle reads pc
	logic is_ld_rr, is_ld_d8, is_alu, is_alu_d8, is_incdec, is_jp, is_st;
	logic executes; // Instruction ends with this machine cycle
	logic [cpu_pkg::data_w-1:0] operand; // Register or immediate source

	// Opcode classes, anything else runs as NOP
	always_comb
	begin
		is_ld_rr = op[7:6] == 2'b01 && op[5:3] != cpu_pkg::reg_none
			&& op[2:0] != cpu_pkg::reg_none; // Also excludes HALT
		is_ld_d8 = op[7:6] == 2'b00 && op[5:3] != cpu_pkg::reg_none && op[2:0] == 3'd6;
		is_alu_d8 = op[7:6] == 2'b11 && op[2:0] == 3'd6;
		is_alu = (op[7:6] == 2'b10 && op[2:0] != cpu_pkg::reg_none) || is_alu_d8;
		is_incdec = op[7:6] == 2'b00 && op[5:3] != cpu_pkg::reg_none && op[2:1] == 2'b10;
		is_jp = op == op_jp;
		is_st = op == op_st_a8;
	end

	assign fetching = state == cpu_pkg::st_ifetch || state == cpu_pkg::st_imml_fetch
		|| state == cpu_pkg::st_immh_fetch;

	// Next machine state and end of instruction
	always_comb
	begin
		state_next = cpu_pkg::st_ifetch;
		executes = 1'b0;
		case (state)
			cpu_pkg::st_ifetch:
				if (is_ld_d8 || is_alu_d8 || is_jp || is_st)
					state_next = cpu_pkg::st_imml_fetch; // Needs an immediate
				else
					executes = is_ld_rr || is_alu || is_incdec;
			cpu_pkg::st_imml_fetch:
				if (is_jp)
					state_next = cpu_pkg::st_immh_fetch;
				else if (is_st)
					state_next = cpu_pkg::st_store;
				else
					executes = is_ld_d8 || is_alu_d8; // d8 forms end here
			cpu_pkg::st_immh_fetch:
				state_next = cpu_pkg::st_jump;
			default:
				state_next = cpu_pkg::st_ifetch; // Jump and store end the instruction
		endcase
	end

	assign src_idx = op[2:0];
	assign operand = (state == cpu_pkg::st_imml_fetch) ? imml : src_data; // d8 replaces source
	assign alu_arg = operand;

	always_comb
	begin
		if (is_incdec)
			alu_op = op[0] ? cpu_pkg::alu_dec : cpu_pkg::alu_inc;
		else
			alu_op = cpu_pkg::alu_op_t'({1'b0, op[5:3]}); // Accumulator op field
	end

	// Write request, valid during clock 3 of the last machine cycle
	assign wr.wr_en = executes && cycle == 2'd3;
	assign wr.wr_idx = is_alu ? cpu_pkg::reg_a : op[5:3];
	assign wr.flag_data = alu_flags;

	always_comb
	begin
		wr.wr_data = operand; // Loads move the source byte
		wr.flag_mask = '0;
		if (is_alu)
		begin
			wr.wr_data = (alu_op == cpu_pkg::alu_cp) ? acc : alu_result; // CP keeps A
			wr.flag_mask = '1;
		end
		else if (is_incdec)
		begin
			wr.wr_data = alu_result;
			wr.flag_mask = '1;
			wr.flag_mask[cpu_pkg::flag_c] = 1'b0; // C untouched by INC/DEC
		end
	end

	// Control state
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			cycle <= '0;
			state <= cpu_pkg::st_ifetch;
			op <= '0; // NOP
			pc <= RESET_PC;
			read <= 1'b0;
			write <= 1'b0;
		end
		else
		begin
			cycle <= cycle + 2'd1;
			case (cycle)
				2'd0:
				begin
					read <= fetching; // High for clocks 1 and 2
					write <= state == cpu_pkg::st_store;
				end
				2'd1:
					if (fetching)
						pc <= pc + 1'b1;
				2'd2:
				begin
					read <= 1'b0;
					write <= 1'b0;
					if (state == cpu_pkg::st_ifetch)
						op <= din;
				end
				default:
				begin
					state <= state_next;
					if (state == cpu_pkg::st_jump)
						pc <= {immh, imml}; // JP target
				end
			endcase
		end
	end

	// Bus and immediate registers
	always_ff @(posedge clk)
	begin
		if (cycle == 2'd0)
		begin
			if (state == cpu_pkg::st_store)
			begin
				adr <= {cpu_pkg::high_page, imml};
				dout <= acc;
			end
			else if (fetching)
				adr <= pc;
		end
		if (cycle == 2'd2 && state == cpu_pkg::st_imml_fetch)
			imml <= din;
		if (cycle == 2'd2 && state == cpu_pkg::st_immh_fetch)
			immh <= din;
	end

endmodule

/* gb_cpu.f */
cpu_pkg.sv
reg_wr_if.sv
alu8.sv
reg_file.sv
cpu_sequencer.sv
gb_cpu.sv
gb_cpu_chk.sv
tb_gb_cpu.sv

/* gb_cpu.sv */
module gb_cpu #(
	parameter logic [cpu_pkg::addr_w-1:0] RESET_PC = '0 // First opcode address
) (
	input logic clk,
	input logic reset,
	output logic [cpu_pkg::addr_w-1:0] adr, // Registered address
	input logic [cpu_pkg::data_w-1:0] din, // Valid while read is high
	output logic [cpu_pkg::data_w-1:0] dout, // Registered write data
	output logic read,
	output logic write,
	output logic [cpu_pkg::addr_w-1:0] pc,
	output logic [cpu_pkg::flag_z:cpu_pkg::flag_c] f
);

	cpu_pkg::reg_idx_t src_idx; // Opcode bits 2..0
	logic [cpu_pkg::data_w-1:0] src_data;
	logic [cpu_pkg::data_w-1:0] dst_data; // A for accumulator ops
	logic [cpu_pkg::data_w-1:0] acc;
	cpu_pkg::alu_op_t alu_op;
	logic [cpu_pkg::data_w-1:0] alu_arg;
	logic [cpu_pkg::data_w-1:0] alu_result;
	logic [cpu_pkg::flag_z:cpu_pkg::flag_c] alu_flags;

	reg_wr_if wr_if (); // Register and flag write requests

	cpu_sequencer #(
		.RESET_PC(RESET_PC)
	) i_cpu_sequencer (
		.clk(clk),
		.reset(reset),
		.adr(adr),
		.dout(dout),
		.din(din),
		.read(read),
		.write(write),
		.pc(pc),
		.wr(wr_if.seq),
		.src_idx(src_idx),
		.src_data(src_data),
		.acc(acc),
		.alu_op(alu_op),
		.alu_arg(alu_arg),
		.alu_result(alu_result),
		.alu_flags(alu_flags)
	);

	// The write index doubles as the read index of the ALU's first operand
	reg_file i_reg_file (
		.clk(clk),
		.reset(reset),
		.wr(wr_if.rf),
		.src_idx(src_idx),
		.dst_idx(wr_if.wr_idx),
		.src_data(src_data),
		.dst_data(dst_data),
		.acc(acc),
		.flags(f)
	);

	alu8 i_alu8 (
		.op(alu_op),
		.acc(dst_data),
		.arg(alu_arg),
		.carry_in(f[cpu_pkg::flag_c]),
		.result(alu_result),
		.flags(alu_flags)
	);

endmodule

/* gb_cpu_chk.sv */
module gb_cpu_chk (
	input logic clk,
	input logic reset,
	input logic [cpu_pkg::addr_w-1:0] adr,
	input logic [cpu_pkg::data_w-1:0] dout,
	input logic read,
	input logic write
);

	int fails = 0; // Count of failed assertions

	// One bus, never both directions
	bus_exclusive: assert property (@(posedge clk) disable iff (reset) !(read && write))
		else
		begin
			fails++;
			$error("read and write high together");
		end

	read_pulse: assert property (@(posedge clk) disable iff (reset)
		$rose(read) |=> read ##1 !read) // Clocks 1 and 2
		else
		begin
			fails++;
			$error("read pulse not two clocks long");
		end

	write_pulse: assert property (@(posedge clk) disable iff (reset)
		$rose(write) |=> write ##1 !write)
		else
		begin
			fails++;
			$error("write pulse not two clocks long");
		end

	// Bus idle one clock into reset and after
	reset_idle: assert property (@(posedge clk) reset |=> !read && !write)
		else
		begin
			fails++;
			$error("bus active during reset");
		end

	read_adr_stable: assert property (@(posedge clk) disable iff (reset)
		read && $past(read) |-> $stable(adr))
		else
		begin
			fails++;
			$error("adr changed during read");
		end

	write_bus_stable: assert property (@(posedge clk) disable iff (reset)
		write && $past(write) |-> $stable(adr) && $stable(dout))
		else
		begin
			fails++;
			$error("adr or dout changed during write");
		end

endmodule

/* reg_file.sv */
module reg_file (
	input logic clk,
	input logic reset,
	reg_wr_if.rf wr,
	input cpu_pkg::reg_idx_t src_idx, // Opcode bits 2..0
	input cpu_pkg::reg_idx_t dst_idx, // Opcode bits 5..3, or A
	output logic [cpu_pkg::data_w-1:0] src_data,
	output logic [cpu_pkg::data_w-1:0] dst_data,
	output logic [cpu_pkg::data_w-1:0] acc,
	output logic [cpu_pkg::flag_z:cpu_pkg::flag_c] flags
);

	// Indexed as in the opcode, slot 6 stays zero
	logic [cpu_pkg::data_w-1:0] gpr [0:7];

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			for (int i = 0; i < 8; i++)
				gpr[i] <= '0;
			flags <= '0;
		end
		else if (wr.wr_en)
		begin
			if (wr.wr_idx != cpu_pkg::reg_none)
				gpr[wr.wr_idx] <= wr.wr_data;
			flags <= (flags & ~wr.flag_mask) | (wr.flag_data & wr.flag_mask); // Masked update
		end
	end

	// Combinational read ports
	assign src_data = gpr[src_idx];
	assign dst_data = gpr[dst_idx]; // INC/DEC operand, A for accumulator ops
	assign acc = gpr[cpu_pkg::reg_a];

endmodule

/* reg_wr_if.sv */
interface reg_wr_if;

	logic wr_en; // One-clock strobe, applied on that clock edge
	cpu_pkg::reg_idx_t wr_idx; // Destination, also selects the dst read port
	logic [cpu_pkg::data_w-1:0] wr_data; // New register value
	logic [cpu_pkg::flag_z:cpu_pkg::flag_c] flag_mask; // Set bit enables that flag
	logic [cpu_pkg::flag_z:cpu_pkg::flag_c] flag_data; // New flag values

	// Sequencer side
	modport seq
	(
		output wr_en, wr_idx, wr_data, flag_mask, flag_data
	);

	// Register file side
	modport rf
	(
		input wr_en, wr_idx, wr_data, flag_mask, flag_data
	);

endinterface

/* tb_gb_cpu.sv */
module tb_gb_cpu;

	localparam logic [15:0] reset_pc = 16'h0100; // First opcode address
	localparam logic [15:0] prog_end = 16'h0f00; // Generated code ends here
	localparam int num_instr = 600;
	localparam int wait_limit = 64; // Clocks allowed before a bus pulse

	logic clk;
	logic reset;
	logic [cpu_pkg::addr_w-1:0] adr;
	logic [cpu_pkg::data_w-1:0] din;
	logic [cpu_pkg::data_w-1:0] dout;
	logic read;
	logic write;
	logic [cpu_pkg::addr_w-1:0] pc;
	logic [cpu_pkg::flag_z:cpu_pkg::flag_c] f;

	logic [7:0] mem [0:65535]; // Program memory, read only
	logic read_q; // Bus levels one clock back
	logic write_q;
	int unsigned clk_cnt;
	integer seed;
	int errors;
	int timeouts;

	logic [15:0] pc_m; // Reference model state
	logic [7:0] rm [0:7]; // Opcode order, slot 6 unused
	logic [3:0] fm; // Z N H C

	gb_cpu #(
		.RESET_PC(reset_pc)
	) i_gb_cpu (
		.clk(clk),
		.reset(reset),
		.adr(adr),
		.din(din),
		.dout(dout),
		.read(read),
		.write(write),
		.pc(pc),
		.f(f)
	);

	bind gb_cpu gb_cpu_chk i_gb_cpu_chk (
		.clk(clk),
		.reset(reset),
		.adr(adr),
		.dout(dout),
		.read(read),
		.write(write)
	);

	always #10 clk = ~clk;

	always @(posedge clk)
	begin
		clk_cnt <= clk_cnt + 1;
		read_q <= read;
		write_q <= write;
		din <= read ? mem[adr] : 8'h00; // Memory answers one clock into the read pulse
	end

	function automatic logic [2:0] rand_reg();
		logic [31:0] r;
		r = $random(seed);
		r = r % 7;
		return (r == 6) ? 3'd7 : r[2:0]; // Skip the (HL) slot
	endfunction

	// Bytes of an instruction, d8 forms are LD r,d8 and ALU d8
	function automatic int instr_bytes(input logic [7:0] op);
		if (op == 8'hc3)
			return 3;
		if (op == 8'he0 || (op[2:0] == 3'd6 && (op[7:6] == 2'b11
			|| (op[7:6] == 2'b00 && op[5:3] != 3'd6))))
			return 2;
		return 1;
	endfunction

	task automatic fill_memory();
		int a;
		int t;
		int k;
		logic [31:0] r;
		logic [7:0] op;
		for (a = 0; a < 65536; a++)
			mem[a] = a[15:8] ^ a[7:0] ^ 8'ha5; // Filler outside the code, from both address bytes
		a = reset_pc;
		while (a < prog_end)
		begin
			r = $random(seed);
			case (r[3:0])
				4'd0, 4'd1, 4'd2: op = {2'b01, rand_reg(), rand_reg()}; // LD r,r'
				4'd3, 4'd4: op = {2'b00, rand_reg(), 3'b110}; // LD r,d8
				4'd5, 4'd6, 4'd7, 4'd15: op = {2'b10, r[10:8], rand_reg()}; // ALU r
				4'd8, 4'd9: op = {2'b11, r[10:8], 3'b110}; // ALU d8
				4'd10, 4'd11: op = {2'b00, rand_reg(), 2'b10, r[11]}; // INC/DEC
				4'd12, 4'd13: op = 8'he0; // LD (a8),A
				default: op = (r[5:4] == 2'd0) ? 8'hc3 : 8'h00; // Rare JP, else NOP
			endcase
			mem[a] = op;
			t = r[31:20];
			t = reset_pc + t % (int'(prog_end) - int'(reset_pc)); // Target inside the code
			for (k = 1; k < instr_bytes(op); k++)
				mem[a + k] = (op == 8'hc3) ? ((k == 1) ? t[7:0] : t[15:8]) : 8'($random(seed));
			a = a + instr_bytes(op);
		end
	endtask

	// Accumulator operations, CP only sets flags
	task automatic alu_ref(input logic [2:0] sel, input logic [7:0] b);
		logic [7:0] a;
		int cin;
		int res;
		a = rm[7];
		cin = (sel == 3'd1 || sel == 3'd3) ? fm[0] : 0;
		case (sel)
			3'd0, 3'd1:
			begin
				res = a + b + cin;
				fm = {res[7:0] == 8'd0, 1'b0, (a[3:0] + b[3:0] + cin) > 15, res > 255};
			end
			3'd4:
			begin
				res = a & b;
				fm = {res[7:0] == 8'd0, 3'b010}; // H set
			end
			3'd5:
			begin
				res = a ^ b;
				fm = {res[7:0] == 8'd0, 3'b000};
			end
			3'd6:
			begin
				res = a | b;
				fm = {res[7:0] == 8'd0, 3'b000};
			end
			default:
			begin
				res = a - b - cin; // SUB, SBC, CP
				fm = {res[7:0] == 8'd0, 1'b1, a[3:0] < b[3:0] + cin, a < b + cin};
			end
		endcase
		if (sel != 3'd7)
			rm[7] = res[7:0];
	endtask

	task automatic execute(input logic [7:0] op, input logic [7:0] lo, input logic [7:0] hi);
		logic [7:0] v;
		v = rm[op[5:3]];
		if (op[7:6] == 2'b01 && op[5:3] != 3'd6 && op[2:0] != 3'd6)
			rm[op[5:3]] = rm[op[2:0]];
		else if (op[7:6] == 2'b00 && op[5:3] != 3'd6 && op[2:0] == 3'd6)
			rm[op[5:3]] = lo;
		else if (op[7:6] == 2'b10 && op[2:0] != 3'd6)
			alu_ref(op[5:3], rm[op[2:0]]);
		else if (op[7:6] == 2'b11 && op[2:0] == 3'd6)
			alu_ref(op[5:3], lo);
		else if (op[7:6] == 2'b00 && op[5:3] != 3'd6 && op[2:1] == 2'b10)
		begin
			rm[op[5:3]] = op[0] ? v - 8'd1 : v + 8'd1;
			if (op[0])
				fm[3:1] = {v == 8'd1, 1'b1, v[3:0] == 4'h0}; // DEC, C kept
			else
				fm[3:1] = {v == 8'hff, 1'b0, v[3:0] == 4'hf}; // INC, C kept
		end
		else if (op == 8'hc3)
			pc_m = {hi, lo};
	endtask

	task automatic compare(input string name, input logic [15:0] got, input logic [15:0] exp);
		assert (got === exp)
		else
		begin
			errors++;
			$display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	// Waits for a read or write rise, sampled between edges
	task automatic wait_pulse(input bit on_write, input string what, output int unsigned t);
		int n;
		bit seen;
		seen = 1'b0;
		t = 0;
		for (n = 0; n < wait_limit && !seen; n++)
		begin
			@(negedge clk);
			seen = on_write ? (write && !write_q) : (read && !read_q);
		end
		if (seen)
			t = clk_cnt;
		else
		begin
			timeouts++;
			$display("Timeout: no %s pulse began within %0d clocks at %0t", what, wait_limit,
				$time);
		end
	endtask

	initial
	begin
		logic [7:0] op;
		logic [7:0] imm [1:2];
		logic [15:0] a16;
		int unsigned t0;
		int unsigned t;
		int unsigned t_prev;
		int nb;
		int mc;
		int mc_prev;
		int i;
		int k;
		int bus_fails;
		seed = 65151;
		errors = 0;
		timeouts = 0;
		clk = 1'b0;
		reset = 1'b1;
		din = 8'h00;
		clk_cnt = 0;
		read_q = 1'b0;
		write_q = 1'b0;
		fill_memory();
		pc_m = reset_pc;
		fm = 4'h0;
		for (i = 0; i < 8; i++)
			rm[i] = 8'h00;
		t_prev = 0;
		mc_prev = 0;
		repeat (16) @(posedge clk);
		reset <= 1'b0;
		for (i = 0; i < num_instr && timeouts == 0; i++)
		begin
			wait_pulse(1'b0, "opcode read", t0);
			if (timeouts == 0)
			begin
				compare("adr", adr, pc_m); // Opcode fetch address
				compare("pc", pc, pc_m);
				compare("f", f, fm);
				if (i > 0)
					compare("fetch interval", t0 - t_prev, 4 * mc_prev);
				op = mem[pc_m];
				nb = instr_bytes(op);
				mc = nb + ((op == 8'hc3 || op == 8'he0) ? 1 : 0); // Jump or store cycle
				imm[1] = 8'h00;
				imm[2] = 8'h00;
				for (k = 1; k < nb && timeouts == 0; k++)
				begin
					a16 = pc_m + k[15:0];
					wait_pulse(1'b0, "immediate read", t);
					compare("adr", adr, a16);
					compare("immediate interval", t - t0, 4 * k);
					imm[k] = mem[a16];
				end
				if (op == 8'he0 && timeouts == 0)
				begin
					wait_pulse(1'b1, "store write", t);
					compare("adr", adr, {8'hff, imm[1]});
					compare("dout", dout, rm[7]);
					compare("store interval", t - t0, 8);
				end
				pc_m = pc_m + nb[15:0];
				execute(op, imm[1], imm[2]);
				t_prev = t0;
				mc_prev = mc;
			end
		end
		bus_fails = i_gb_cpu.i_gb_cpu_chk.fails;
		$display("Checks done: %0d errors, %0d timeouts, %0d bus assertion failures", errors,
			timeouts, bus_fails);
		if (errors == 0 && timeouts == 0 && bus_fails == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule
